/* include/l2c_defs.svh */
`ifndef L2C_DEFS_SVH
`define L2C_DEFS_SVH

// array geometry
`define L2C_WAYS 4
`define L2C_SETS 16

// word address split
`define L2C_IDX_W 4
`define L2C_TAG_W 8
`define L2C_ADDR_W 12

// data word and byte enables
`define L2C_DATA_W 32
`define L2C_BEN_W 4

// one lru age per way, 0 is most recent
`define L2C_AGE_W 2

`endif

/* design/l2c_req_pkg.sv */
`include "l2c_defs.svh"

package l2c_req_pkg;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1, // merge bytes, hit only
    OP_FILL  = 2'd2
  } l2c_op_t;

  // tag sits above index in the word address
  typedef struct packed {
    logic [`L2C_TAG_W-1:0] tag;
    logic [`L2C_IDX_W-1:0] index;
  } l2c_addr_t;

  typedef logic [`L2C_DATA_W-1:0] l2c_data_t;

  typedef logic [`L2C_BEN_W-1:0] l2c_ben_t;

endpackage

/* design/l2c_repl_pkg.sv */
`include "l2c_defs.svh"

package l2c_repl_pkg;

  // one bit per way
  typedef logic [`L2C_WAYS-1:0] l2c_way_vec_t;

  // lru age, WAYS-1 is the eviction candidate
  typedef logic [`L2C_AGE_W-1:0] l2c_age_t;

endpackage

/* design/l2c_way_if.sv */
`include "l2c_defs.svh"

interface l2c_way_if
  import l2c_req_pkg::*, l2c_repl_pkg::*;
();

  // request side
  logic                  lookup;
  logic                  commit;
  l2c_op_t               op;
  logic [`L2C_TAG_W-1:0] tag;
  logic [`L2C_IDX_W-1:0] index;
  l2c_data_t             wdata;
  l2c_ben_t              ben;

  // per way results, one element per way
  l2c_way_vec_t hit_vec;
  l2c_way_vec_t valid_vec;
  l2c_age_t     age_vec   [`L2C_WAYS];
  l2c_data_t    rdata_arr [`L2C_WAYS];

  // merged results
  l2c_way_vec_t sel;
  l2c_age_t     target_age;
  logic         done;
  logic         hit_r;
  l2c_data_t    rdata_r;

  modport feed (
    output lookup, commit, op, tag, index, wdata, ben,
    input  done
  );

  modport way (
    input  lookup, commit, op, tag, index, wdata, ben, sel, target_age,
    output hit_vec, valid_vec, age_vec, rdata_arr
  );

  modport drain (
    input  lookup, op, hit_vec, valid_vec, age_vec, rdata_arr,
    output sel, target_age, done, hit_r, rdata_r
  );

endinterface

/* design/l2c_req_ctrl.sv */
module l2c_req_ctrl
  import l2c_req_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  l2c_op_t   op,
  input  l2c_addr_t addr,
  input  l2c_data_t wdata,
  input  l2c_ben_t  ben,
  output logic      ack,
  l2c_way_if.feed   bus
);

  logic busy;
  logic start;

  // new request only once the previous ack has been seen low
  assign start = req && !ack && !busy;

  // ways write on the same edge that raises ack
  assign bus.commit = bus.done && busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      ack        <= 1'b0;
      bus.lookup <= 1'b0;
    end else begin
      bus.lookup <= start; // one cycle strobe
      if (start) begin
        busy <= 1'b1;
      end
      if (bus.done && busy) begin
        ack <= 1'b1;
      end else if (ack && !req) begin
        // host dropped req so the handshake closes
        ack  <= 1'b0;
        busy <= 1'b0;
      end
    end
  end

  // request fields held for the whole transaction
  always_ff @(posedge clk) begin
    if (start) begin
      bus.op    <= op;
      bus.tag   <= addr.tag;
      bus.index <= addr.index;
      bus.wdata <= wdata;
      bus.ben   <= ben;
    end
  end

  // ack only after a lookup has gone through the ways and the merger
  ack_after_lookup: assert property (
    @(posedge clk) disable iff (rst)
    $rose(ack) |-> busy && $past(busy, 3)
  ) else $error("ack rose without a request in flight");

endmodule

/* design/l2c_way.sv */
`include "l2c_defs.svh"

module l2c_way
  import l2c_req_pkg::*, l2c_repl_pkg::*;
#(
  parameter int WAY_ID = 0
) (
  input logic    clk,
  input logic    rst,
  l2c_way_if.way bus
);

  logic [`L2C_TAG_W-1:0] tag_mem  [`L2C_SETS];
  l2c_data_t             data_mem [`L2C_SETS];
  l2c_age_t              age_mem  [`L2C_SETS];
  logic [`L2C_SETS-1:0]  valid_mem;

  // addressed entry, registered on lookup
  logic [`L2C_TAG_W-1:0] tag_q;
  l2c_data_t             data_q;
  l2c_age_t              age_q;
  logic                  valid_q;

  logic sel_me;
  logic age_upd;

  function automatic l2c_data_t byte_merge(
    input l2c_ben_t  be,
    input l2c_data_t old_w,
    input l2c_data_t new_w
  );
    l2c_data_t res;
    for (int b = 0; b < `L2C_BEN_W; b++) begin
      res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  assign sel_me  = bus.sel[WAY_ID];
  assign age_upd = bus.commit && (|bus.sel); // any selected access ages the set

  assign bus.hit_vec[WAY_ID]   = valid_q && (tag_q == bus.tag);
  assign bus.valid_vec[WAY_ID] = valid_q;
  assign bus.age_vec[WAY_ID]   = age_q;
  assign bus.rdata_arr[WAY_ID] = data_q;

  // tag and data storage
  always_ff @(posedge clk) begin
    if (bus.lookup) begin
      tag_q  <= tag_mem[bus.index];
      data_q <= data_mem[bus.index];
    end
    if (bus.commit && sel_me) begin
      if (bus.op == OP_FILL) begin
        tag_mem[bus.index]  <= bus.tag;
        data_mem[bus.index] <= bus.wdata;
      end else if (bus.op == OP_WRITE) begin
        data_mem[bus.index] <= byte_merge(bus.ben, data_q, bus.wdata);
      end
    end
  end

  // valid bits and lru ages
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_mem <= '0;
      valid_q   <= 1'b0;
      age_q     <= '0;
      for (int s = 0; s < `L2C_SETS; s++) begin
        age_mem[s] <= l2c_age_t'(WAY_ID); // ways start ordered by id
      end
    end else begin
      if (bus.lookup) begin
        valid_q <= valid_mem[bus.index];
        age_q   <= age_mem[bus.index];
      end
      if (bus.commit && sel_me && bus.op == OP_FILL) begin
        valid_mem[bus.index] <= 1'b1;
      end
      if (age_upd) begin
        if (sel_me) begin
          age_mem[bus.index] <= '0;
        end else if (age_q < bus.target_age) begin
          age_mem[bus.index] <= age_q + 1'b1;
        end
      end
    end
  end

  // sel comes back from the merger two cycles after lookup
  sel_in_commit: assert property (
    @(posedge clk) disable iff (rst)
    bus.sel[WAY_ID] |-> bus.commit
  ) else $error("way %0d selected outside a commit cycle", WAY_ID);

endmodule

/* design/l2c_resp_merge.sv */
`include "l2c_defs.svh"

module l2c_resp_merge
  import l2c_req_pkg::*, l2c_repl_pkg::*;
(
  input logic      clk,
  input logic      rst,
  l2c_way_if.drain bus
);

  logic         lk_d; // lookup delayed, way registers valid now
  logic         any_hit;
  l2c_data_t    hit_data;
  l2c_way_vec_t victim;
  l2c_way_vec_t sel_next;
  l2c_age_t     sel_age;

  assign any_hit = |bus.hit_vec;

  always_comb begin
    hit_data = '0;
    for (int w = 0; w < `L2C_WAYS; w++) begin
      if (bus.hit_vec[w]) begin
        hit_data = bus.rdata_arr[w];
      end
    end
  end

  // lowest invalid way first, else the oldest
  always_comb begin
    victim = '0;
    if (&bus.valid_vec) begin
      for (int w = 0; w < `L2C_WAYS; w++) begin
        if (bus.age_vec[w] == l2c_age_t'(`L2C_WAYS - 1)) begin
          victim = l2c_way_vec_t'(1) << w;
        end
      end
    end else begin
      for (int w = `L2C_WAYS - 1; w >= 0; w--) begin
        if (!bus.valid_vec[w]) begin
          victim = l2c_way_vec_t'(1) << w;
        end
      end
    end
  end

  always_comb begin
    if (any_hit) begin
      sel_next = bus.hit_vec;
    end else if (bus.op == OP_FILL) begin
      sel_next = victim;
    end else begin
      sel_next = '0; // read or write miss touches nothing
    end
    sel_age = '0;
    for (int w = 0; w < `L2C_WAYS; w++) begin
      if (sel_next[w]) begin
        sel_age = bus.age_vec[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lk_d     <= 1'b0;
      bus.done <= 1'b0;
      bus.sel  <= '0;
      bus.hit_r <= 1'b0;
    end else begin
      lk_d     <= bus.lookup;
      bus.done <= lk_d;
      bus.sel  <= lk_d ? sel_next : '0;
      if (lk_d) begin
        bus.hit_r <= any_hit;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lk_d) begin
      bus.rdata_r    <= hit_data;
      bus.target_age <= sel_age;
    end
  end

  // a tag lives in at most one way of a set
  sel_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(bus.sel)
  ) else $error("more than one way selected: %b", bus.sel);

endmodule

/* design/l2c_top.sv */
`include "l2c_defs.svh"

module l2c_top
  import l2c_req_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  l2c_op_t   op,
  input  l2c_addr_t addr,
  input  l2c_data_t wdata,
  input  l2c_ben_t  ben,
  output logic      ack,
  output logic      hit,
  output l2c_data_t rdata
);

  l2c_way_if bus_if ();

  l2c_req_ctrl req_ctrl_i (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .op    (op),
    .addr  (addr),
    .wdata (wdata),
    .ben   (ben),
    .ack   (ack),
    .bus   (bus_if.feed)
  );

  for (genvar w = 0; w < `L2C_WAYS; w++) begin : g_way
    l2c_way #(
      .WAY_ID (w)
    ) way_i (
      .clk (clk),
      .rst (rst),
      .bus (bus_if.way)
    );
  end

  l2c_resp_merge resp_merge_i (
    .clk (clk),
    .rst (rst),
    .bus (bus_if.drain)
  );

  // results are registered in the merger and held through ack
  assign hit   = bus_if.hit_r;
  assign rdata = bus_if.rdata_r;

endmodule

/* dv/l2c_tb.sv */
`include "l2c_defs.svh"

module l2c_tb
  import l2c_req_pkg::*;
();

  localparam int POOL_OPS    = 400;
  localparam int TOTAL_OPS   = 4 + 24 + 32 + 11 + POOL_OPS;
  localparam int CYCLE_LIMIT = TOTAL_OPS * 8 + 200;

  logic      clk = 1'b0;
  logic      rst;
  logic      req;
  l2c_op_t   op;
  l2c_addr_t addr;
  l2c_data_t wdata;
  l2c_ben_t  ben;
  logic      ack;
  logic      hit;
  l2c_data_t rdata;

  logic [15:0] lfsr_q = 16'd42534;
  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  l2c_addr_t   fill_a [12];

  // reference model, per set and way
  logic [`L2C_TAG_W-1:0] m_tag   [`L2C_SETS][`L2C_WAYS];
  logic                  m_valid [`L2C_SETS][`L2C_WAYS];
  l2c_data_t             m_data  [`L2C_SETS][`L2C_WAYS];
  int                    m_age   [`L2C_SETS][`L2C_WAYS];

  l2c_top dut_i (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .op    (op),
    .addr  (addr),
    .wdata (wdata),
    .ben   (ben),
    .ack   (ack),
    .hit   (hit),
    .rdata (rdata)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic l2c_addr_t rand_addr();
    l2c_addr_t a;
    a.tag   = `L2C_TAG_W'(rand_bits(`L2C_TAG_W));
    a.index = `L2C_IDX_W'(rand_bits(`L2C_IDX_W));
    return a;
  endfunction

  // way holding the address, -1 when absent
  function automatic int model_find(input l2c_addr_t a);
    int h;
    h = -1;
    for (int w = 0; w < `L2C_WAYS; w++) begin
      if (m_valid[a.index][w] && m_tag[a.index][w] == a.tag) h = w;
    end
    return h;
  endfunction

  task automatic model_access(input l2c_op_t o, input l2c_addr_t a, input l2c_data_t d,
                              input l2c_ben_t be, output logic exp_hit,
                              output l2c_data_t exp_data);
    int        h;
    int        s;
    int        tgt;
    l2c_data_t mask;
    h        = model_find(a);
    s        = h;
    exp_hit  = (h >= 0);
    exp_data = '0;
    if (exp_hit) exp_data = m_data[a.index][h];
    if (!exp_hit && o == OP_FILL) begin
      for (int w = 0; w < `L2C_WAYS; w++) begin
        if (s < 0 && !m_valid[a.index][w]) s = w;
      end
      for (int w = 0; w < `L2C_WAYS; w++) begin
        if (s < 0 && m_age[a.index][w] == `L2C_WAYS - 1) s = w;
      end
    end
    if (s >= 0) begin
      tgt = m_age[a.index][s];
      if (o == OP_FILL) begin
        m_tag[a.index][s]   = a.tag;
        m_valid[a.index][s] = 1'b1;
        m_data[a.index][s]  = d;
      end else if (o == OP_WRITE) begin
        for (int b = 0; b < `L2C_BEN_W; b++) mask[8*b +: 8] = {8{be[b]}};
        m_data[a.index][s] = (m_data[a.index][s] & ~mask) | (d & mask);
      end
      for (int w = 0; w < `L2C_WAYS; w++) begin
        if (w == s) m_age[a.index][w] = 0;
        else if (m_age[a.index][w] < tgt) m_age[a.index][w]++;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic handshake_error(input string what);
    $display("handshake problem: %s", what);
    err_cnt++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // one four phase transaction, checked against the model
  task automatic run_op(input l2c_op_t o, input l2c_addr_t a);
    logic      exp_hit;
    l2c_data_t exp_data;
    l2c_data_t d;
    l2c_ben_t  be;
    int        waited;
    int        hold;
    d  = rand_bits(32);
    be = `L2C_BEN_W'(rand_bits(`L2C_BEN_W));
    if (ack) handshake_error("ack high before a new request");
    req   = 1'b1;
    op    = o;
    addr  = a;
    wdata = d;
    ben   = be;
    waited = 0;
    while (!ack && waited < 8) begin
      next_cycle();
      waited++;
    end
    if (!ack) begin
      handshake_error("no ack within 8 cycles of req");
    end else begin
      model_access(o, a, d, be, exp_hit, exp_data);
      check_value("hit", 32'(hit), 32'(exp_hit));
      if (exp_hit) check_value("rdata", rdata, exp_data);
      hold = int'(rand_bits(1)); // sometimes keep req up an extra cycle
      repeat (hold) begin
        next_cycle();
        if (!ack) handshake_error("ack dropped while req was still high");
      end
    end
    req = 1'b0;
    next_cycle();
    if (ack) handshake_error("ack still high after req dropped");
    next_cycle();
    if (ack) handshake_error("ack rose again without a new request");
  endtask

  initial begin
    int        e0;
    int        idx;
    int        kind;
    l2c_addr_t a;
    l2c_addr_t gone_a [4];
    l2c_op_t   o;
    logic [`L2C_TAG_W-1:0] t0;

    rst   = 1'b1;
    req   = 1'b0;
    op    = OP_READ;
    addr  = '0;
    wdata = '0;
    ben   = '0;
    for (int s = 0; s < `L2C_SETS; s++) begin
      for (int w = 0; w < `L2C_WAYS; w++) begin
        m_tag[s][w]   = '0;
        m_valid[s][w] = 1'b0;
        m_data[s][w]  = '0;
        m_age[s][w]   = w;
      end
    end
    repeat (8) @(posedge clk);
    #5;
    rst = 1'b0;

    e0 = err_cnt;
    check_value("ack", 32'(ack), 32'd0);
    repeat (4) run_op(OP_READ, rand_addr());
    report_test("reset read", e0);

    e0 = err_cnt;
    for (int i = 0; i < 12; i++) begin
      fill_a[i] = rand_addr();
      run_op(OP_FILL, fill_a[i]);
    end
    for (int i = 0; i < 12; i++) run_op(OP_READ, fill_a[i]);
    report_test("fill then read", e0);

    e0 = err_cnt;
    for (int i = 0; i < 12; i++) run_op(OP_WRITE, fill_a[i]);
    for (int i = 0; i < 4; i++) begin
      a = rand_addr();
      while (model_find(a) >= 0) a = rand_addr();
      gone_a[i] = a;
      run_op(OP_WRITE, a); // miss, must not allocate
    end
    for (int i = 0; i < 12; i++) run_op(OP_READ, fill_a[i]);
    for (int i = 0; i < 4; i++) run_op(OP_READ, gone_a[i]);
    report_test("byte writes", e0);

    // find an untouched set
    e0  = err_cnt;
    idx = int'(rand_bits(`L2C_IDX_W));
    while (m_valid[idx][0] || m_valid[idx][1] || m_valid[idx][2] || m_valid[idx][3]) begin
      idx = (idx + 1) % `L2C_SETS;
    end
    t0      = `L2C_TAG_W'(rand_bits(`L2C_TAG_W));
    a.index = `L2C_IDX_W'(idx);
    for (int k = 0; k < 4; k++) begin
      a.tag = t0 + `L2C_TAG_W'(k);
      run_op(OP_FILL, a);
    end
    a.tag = t0 + 1;
    run_op(OP_READ, a);
    a.tag = t0 + 4;
    run_op(OP_FILL, a); // evicts the oldest way
    for (int k = 0; k < 5; k++) begin
      a.tag = t0 + `L2C_TAG_W'(k);
      run_op(OP_READ, a);
    end
    report_test("lru eviction", e0);

    e0 = err_cnt;
    for (int i = 0; i < POOL_OPS; i++) begin
      kind    = int'(rand_bits(2));
      a.index = `L2C_IDX_W'(rand_bits(2));
      a.tag   = `L2C_TAG_W'(rand_bits(3));
      case (kind)
        1:       o = OP_WRITE;
        2:       o = OP_FILL;
        default: o = OP_READ;
      endcase
      run_op(o, a);
    end
    report_test("random pool", e0);

    $display("tests: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
design/l2c_req_pkg.sv
design/l2c_repl_pkg.sv
design/l2c_way_if.sv
design/l2c_req_ctrl.sv
design/l2c_way.sv
design/l2c_resp_merge.sv
design/l2c_top.sv
dv/l2c_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= l2c_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
